//--- test/ifetch_cases.txt
// fetch cases, one per line, all fields hex
// redirect_pc prv parcels ready_stall_density (0 never low, 7 mostly low)
// the first line is the stream out of reset, no redirect is driven for it
// reset stream, ready always high
00000100 3 0c 0
// mid-stream redirects with light and heavy ready stalls
00002000 3 20 3
00003000 0 18 5
00005000 1 10 7
// io region, every parcel carries a bus error
80000040 3 08 2
80001000 1 08 0
80002000 0 06 4
// misaligned targets
00000402 3 0a 2
00000581 0 06 4
00000603 1 06 0
// plain streams again
0000f000 3 14 1
00000010 0 0c 0

//--- ifetch_top.f
+incdir+hw
hw/ifetch_pkg.sv
hw/ifetch_pc_seq.sv
hw/ifetch_noicache.sv
hw/ifetch_biu.sv
hw/ifetch_top.sv
test/ifetch_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the fetch testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f ifetch_top.f --top-module ifetch_tb -o ifetch_sim \
  && ./obj_dir/ifetch_sim | tee /dev/stderr | grep -q "All tests passed" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- test/ifetch_tb.sv
`timescale 1ns/1ns
`include "ifetch_defines.svh"

module ifetch_tb;

  localparam int                  MAX_CASES = 16;
  localparam logic [`IF_XLEN-1:0] RESET_PC  = `IF_RESET_PC;
  localparam logic [`IF_XLEN-1:0] INSN_KEY  = 32'h5a5a_a5a5;

  logic                  clk = 1'b0;
  logic                  rstn;
  ifetch_pkg::redirect_t redirect;
  ifetch_pkg::parcel_t   parcel;
  logic                  parcel_valid;
  logic                  parcel_ready;
  logic [`IF_XLEN-1:0]   haddr;
  ifetch_pkg::htrans_e   htrans;
  ifetch_pkg::hsize_e    hsize;
  ifetch_pkg::hburst_e   hburst;
  logic [3:0]            hprot;
  logic                  hwrite;
  logic [`IF_XLEN-1:0]   hrdata;
  logic                  hready;
  logic                  hresp;

  // four words per case: pc, prv, parcel count, stall density
  logic [31:0]         case_mem [MAX_CASES*4];
  logic [31:0]         lfsr = 32'hffbe;
  int                  n_errors = 0;
  int                  n_compares = 0;
  int                  n_parcels = 0;
  int                  cycle_limit = 0;
  // expected stream of the running case
  logic [`IF_XLEN-1:0] exp_pc;
  logic [1:0]          exp_prv;
  logic                cur_io;
  // next address expected on the bus
  logic [`IF_XLEN-1:0] fetch_pc;
  int                  target = 0;
  int                  consumed = 0;
  logic [31:0]         density = '0;
  // next case, picked up in the redirect cycle
  logic                redir_pend = 1'b0;
  logic [`IF_XLEN-1:0] redir_pc;
  logic [1:0]          redir_prv;
  int                  stg_target;
  logic [31:0]         stg_density;
  // history for the hold and mask checks
  logic                prev_hold = 1'b0;
  ifetch_pkg::parcel_t prev_parcel;
  logic                flush_seen = 1'b0;
  logic                check_idle = 1'b0;
  // ahb slave, current and next state
  logic                mem_busy = 1'b0;
  logic [1:0]          mem_wait = 2'd0;
  logic [`IF_XLEN-1:0] mem_adr = '0;
  logic                mem_busy_n = 1'b0;
  logic [1:0]          mem_wait_n = 2'd0;
  logic [`IF_XLEN-1:0] mem_adr_n = '0;

  ifetch_top ifetch_top_i (
    .clk          (clk),
    .rstn         (rstn),
    .redirect     (redirect),
    .parcel       (parcel),
    .parcel_valid (parcel_valid),
    .parcel_ready (parcel_ready),
    .haddr        (haddr),
    .htrans       (htrans),
    .hsize        (hsize),
    .hburst       (hburst),
    .hprot        (hprot),
    .hwrite       (hwrite),
    .hrdata       (hrdata),
    .hready       (hready),
    .hresp        (hresp)
  );

  always #50 clk = ~clk;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // fibonacci taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output logic [3:0] bits);
    bits = 4'b0000;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      bits = {bits[2:0], lfsr[0]};
    end
  endtask

  task automatic report_mismatch(input string name, input logic [65:0] got,
                                 input logic [65:0] exp);
    $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    n_errors++;
  endtask

  task automatic print_counts();
    $display("parcels consumed %0d, parcel compares %0d, errors %0d",
             n_parcels, n_compares, n_errors);
  endtask

  //////////////////////////////////////////////////
  // per-cycle sampling and driving
  //////////////////////////////////////////////////

  // everything is stable at the falling edge
  // and equals what the dut sees at the next rising edge
  task automatic sample_cycle();
    logic       masked;
    logic [3:0] exp_hprot;
    logic [3:0] bits;
    @(negedge clk);
    masked = redirect.valid || flush_seen;
    if (redirect.valid) begin
      // new stream starts here
      exp_pc   = redirect.pc;
      exp_prv  = redirect.prv;
      cur_io   = redirect.pc[`IF_IO_BIT];
      fetch_pc = redirect.pc;
      target   = stg_target;
      density  = stg_density;
      consumed = 0;
    end
    if (hwrite !== 1'b0) begin
      report_mismatch("hwrite", 66'(hwrite), 66'(1'b0));
    end
    if (check_idle && htrans != ifetch_pkg::IDLE) begin
      report_mismatch("htrans", 66'(htrans), 66'(ifetch_pkg::IDLE));
    end
    check_idle = 1'b0;
    if (htrans == ifetch_pkg::NONSEQ) begin
      if (hsize != ifetch_pkg::WORD) begin
        report_mismatch("hsize", 66'(hsize), 66'(ifetch_pkg::WORD));
      end
      if (hburst != ifetch_pkg::SINGLE) begin
        report_mismatch("hburst", 66'(hburst), 66'(ifetch_pkg::SINGLE));
      end
      // address phase in the redirect cycle may still be the old stream
      // instruction fetch, not bufferable, privileged unless user
      exp_hprot = {~cur_io, 1'b0, exp_prv != 2'b00, 1'b0};
      if (!redirect.valid && hprot !== exp_hprot) begin
        report_mismatch("hprot", 66'(hprot), 66'(exp_hprot));
      end
      // fetches go out in order, word aligned
      if (!redirect.valid) begin
        if (haddr !== {fetch_pc[`IF_XLEN-1:2], 2'b00}) begin
          report_mismatch("haddr", 66'(haddr), 66'({fetch_pc[`IF_XLEN-1:2], 2'b00}));
        end
        fetch_pc = fetch_pc + 32'd4;
      end
    end
    if (masked) begin
      if (parcel_valid) begin
        report_mismatch("parcel_valid", 66'(parcel_valid), 66'(1'b0));
      end
    end else begin
      if (prev_hold && !parcel_valid) begin
        report_mismatch("parcel_valid", 66'(parcel_valid), 66'(1'b1));
      end
      if (prev_hold && parcel_valid && parcel !== prev_parcel) begin
        report_mismatch("parcel", parcel, prev_parcel);
      end
      if (parcel_valid) begin
        // head must be the next expected parcel, stale ones fail here
        if (parcel.pc !== exp_pc) begin
          report_mismatch("parcel.pc", 66'(parcel.pc), 66'(exp_pc));
        end
        if (parcel.insn !== ({exp_pc[`IF_XLEN-1:2], 2'b00} ^ INSN_KEY)) begin
          report_mismatch("parcel.insn", 66'(parcel.insn),
                          66'({exp_pc[`IF_XLEN-1:2], 2'b00} ^ INSN_KEY));
        end
        if (parcel.misaligned !== (|exp_pc[1:0])) begin
          report_mismatch("parcel.misaligned", 66'(parcel.misaligned), 66'(|exp_pc[1:0]));
        end
        if (parcel.bus_err !== exp_pc[`IF_IO_BIT]) begin
          report_mismatch("parcel.bus_err", 66'(parcel.bus_err), 66'(exp_pc[`IF_IO_BIT]));
        end
        n_compares++;
        if (parcel_ready) begin
          consumed++;
          n_parcels++;
          exp_pc = exp_pc + 32'd4;
        end
      end
    end
    prev_hold   = parcel_valid && !parcel_ready && !masked;
    prev_parcel = parcel;
    flush_seen  = redirect.valid;
    // slave next state
    mem_busy_n = mem_busy;
    mem_wait_n = mem_wait;
    mem_adr_n  = mem_adr;
    if (mem_busy) begin
      if (mem_wait == 2'd0) begin
        mem_busy_n = 1'b0;
      end else begin
        mem_wait_n = mem_wait - 2'd1;
      end
    end
    if (htrans == ifetch_pkg::NONSEQ && hready) begin
      // 0 to 3 wait states
      draw_bits(2, bits);
      mem_busy_n = 1'b1;
      mem_adr_n  = haddr;
      mem_wait_n = bits[1:0];
    end
  endtask

  task automatic drive_inputs();
    logic [3:0] bits;
    mem_busy = mem_busy_n;
    mem_wait = mem_wait_n;
    mem_adr  = mem_adr_n;
    hready   = !mem_busy || (mem_wait == 2'd0);
    hrdata   = mem_busy ? (mem_adr ^ INSN_KEY) : '0;
    // io region answers with an error
    hresp    = mem_busy && mem_adr[`IF_IO_BIT];
    draw_bits(3, bits);
    parcel_ready = (consumed < target) && !(bits[2:0] < density[2:0]);
    if (redir_pend) begin
      redirect.valid = 1'b1;
      redirect.pc    = redir_pc;
      redirect.prv   = redir_prv;
      redir_pend     = 1'b0;
    end else begin
      redirect = '0;
    end
  endtask

  task automatic run_cycle();
    sample_cycle();
    @(posedge clk);
    #10;
    drive_inputs();
  endtask

  //////////////////////////////////////////////////
  // watchdog
  //////////////////////////////////////////////////

  initial begin
    int timeout_cnt;
    timeout_cnt = 0;
    @(posedge clk);
    while (timeout_cnt < cycle_limit) begin
      @(posedge clk);
      timeout_cnt++;
    end
    $display("timeout: the cases did not finish within %0d cycles", cycle_limit);
    print_counts();
    $display("Some tests failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int n_cases;
    int total;
    rstn         = 1'b0;
    redirect     = '0;
    parcel_ready = 1'b0;
    hready       = 1'b1;
    hrdata       = '0;
    hresp        = 1'b0;
    for (int i = 0; i < MAX_CASES * 4; i++) begin
      case_mem[i] = '0;
    end
    $readmemh("test/ifetch_cases.txt", case_mem);
    n_cases = 0;
    total   = 0;
    // a zero count ends the list
    while (n_cases < MAX_CASES && case_mem[4*n_cases+2] != 32'd0) begin
      total = total + int'(case_mem[4*n_cases+2]);
      n_cases++;
    end
    cycle_limit = 40 * total + 16 * n_cases + 16;
    if (n_cases == 0) begin
      $display("no test cases were read from the cases file");
      n_errors++;
    end
    if (case_mem[0] != RESET_PC) begin
      $display("the first case does not start at the reset address");
      n_errors++;
    end

    // reset, bus idle and nothing offered to decode
    repeat (4) begin
      @(negedge clk);
      if (htrans != ifetch_pkg::IDLE) begin
        report_mismatch("htrans", 66'(htrans), 66'(ifetch_pkg::IDLE));
      end
      if (parcel_valid) begin
        report_mismatch("parcel_valid", 66'(parcel_valid), 66'(1'b0));
      end
      @(posedge clk);
    end
    #10;
    rstn       = 1'b1;
    // first case is the stream out of reset in machine mode
    exp_pc     = RESET_PC;
    exp_prv    = 2'b11;
    cur_io     = RESET_PC[`IF_IO_BIT];
    fetch_pc   = RESET_PC;
    target     = int'(case_mem[2]);
    density    = case_mem[3];
    check_idle = 1'b1;
    drive_inputs();

    for (int ci = 0; ci < n_cases; ci++) begin
      if (ci > 0) begin
        // redirect lands while the queue is full from the last case
        redir_pend  = 1'b1;
        redir_pc    = case_mem[4*ci];
        redir_prv   = case_mem[4*ci+1][1:0];
        stg_target  = int'(case_mem[4*ci+2]);
        stg_density = case_mem[4*ci+3];
        run_cycle();
        run_cycle();
      end
      while (consumed < target) begin
        run_cycle();
      end
      // ready low, let the queue fill and stall
      repeat (8) begin
        run_cycle();
      end
    end

    print_counts();
    if (n_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- hw/ifetch_top.sv
`timescale 1ns/1ns
`include "ifetch_defines.svh"

module ifetch_top (
  input  logic                  clk,
  input  logic                  rstn,
  input  ifetch_pkg::redirect_t redirect,
  output ifetch_pkg::parcel_t   parcel,
  output logic                  parcel_valid,
  input  logic                  parcel_ready,
  output logic [`IF_XLEN-1:0]   haddr,
  output ifetch_pkg::htrans_e   htrans,
  output ifetch_pkg::hsize_e    hsize,
  output ifetch_pkg::hburst_e   hburst,
  output logic [3:0]            hprot,
  output logic                  hwrite,
  input  logic [`IF_XLEN-1:0]   hrdata,
  input  logic                  hready,
  input  logic                  hresp
);

  // sequencer to fetch block
  logic [`IF_XLEN-1:0]  nxt_pc;
  logic [1:0]           prv;
  logic                 stall_nxt_pc;
  // fetch block to bus interface unit
  logic                 stb;
  logic                 stb_ack;
  ifetch_pkg::biu_req_t biu_req;
  ifetch_pkg::biu_rsp_t biu_rsp;

  //////////////////////////////////////////////////
  // fetch path
  //////////////////////////////////////////////////

  // stb_ack only rises with stb, so it marks a taken request
  ifetch_pc_seq u_pc_seq (
    .clk          (clk),
    .rstn         (rstn),
    .redirect     (redirect),
    .stall_nxt_pc (stall_nxt_pc),
    .stb_fire     (stb_ack),
    .nxt_pc       (nxt_pc),
    .prv          (prv)
  );

  // every redirect flushes the queue
  ifetch_noicache u_noicache (
    .clk          (clk),
    .rstn         (rstn),
    .nxt_pc       (nxt_pc),
    .prv          (prv),
    .flush        (redirect.valid),
    .parcel_ready (parcel_ready),
    .stb_ack      (stb_ack),
    .biu_rsp      (biu_rsp),
    .stall_nxt_pc (stall_nxt_pc),
    .parcel       (parcel),
    .parcel_valid (parcel_valid),
    .stb          (stb),
    .biu_req      (biu_req)
  );

  ifetch_biu u_biu (
    .clk     (clk),
    .rstn    (rstn),
    .stb     (stb),
    .biu_req (biu_req),
    .hrdata  (hrdata),
    .hready  (hready),
    .hresp   (hresp),
    .stb_ack (stb_ack),
    .biu_rsp (biu_rsp),
    .haddr   (haddr),
    .htrans  (htrans),
    .hsize   (hsize),
    .hburst  (hburst),
    .hprot   (hprot),
    .hwrite  (hwrite)
  );

endmodule

//--- hw/ifetch_biu.sv
`timescale 1ns/1ns
`include "ifetch_defines.svh"

module ifetch_biu (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 stb,
  input  ifetch_pkg::biu_req_t biu_req,
  input  logic [`IF_XLEN-1:0]  hrdata,
  input  logic                 hready,
  input  logic                 hresp,
  output logic                 stb_ack,
  output ifetch_pkg::biu_rsp_t biu_rsp,
  output logic [`IF_XLEN-1:0]  haddr,
  output ifetch_pkg::htrans_e  htrans,
  output ifetch_pkg::hsize_e   hsize,
  output ifetch_pkg::hburst_e  hburst,
  output logic [3:0]           hprot,
  output logic                 hwrite
);

  ifetch_pkg::biu_state_e state;
  // request held through address and data phase
  ifetch_pkg::biu_req_t   req_q;
  // last cycle of the data phase
  logic                   data_done;

  //////////////////////////////////////////////////
  // request acceptance
  //////////////////////////////////////////////////

  assign data_done = (state == ifetch_pkg::BIU_DATA) && hready;

  // one read outstanding at most
  // next one may start as the current data phase ends
  assign stb_ack = stb && ((state == ifetch_pkg::BIU_IDLE) || data_done);

  always_ff @(posedge clk) begin
    if (stb_ack) begin
      req_q <= biu_req;
    end
  end

  //////////////////////////////////////////////////
  // transfer fsm
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= ifetch_pkg::BIU_IDLE;
    end else begin
      case (state)
        ifetch_pkg::BIU_IDLE: begin
          if (stb_ack) begin
            state <= ifetch_pkg::BIU_ADDR;
          end
        end
        ifetch_pkg::BIU_ADDR: begin
          // address phase ends with hready
          if (hready) begin
            state <= ifetch_pkg::BIU_DATA;
          end
        end
        ifetch_pkg::BIU_DATA: begin
          // wait states keep us here
          if (hready) begin
            state <= stb_ack ? ifetch_pkg::BIU_ADDR : ifetch_pkg::BIU_IDLE;
          end
        end
        default: begin
          state <= ifetch_pkg::BIU_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // ahb-lite master outputs
  //////////////////////////////////////////////////

  assign htrans = (state == ifetch_pkg::BIU_ADDR) ? ifetch_pkg::NONSEQ : ifetch_pkg::IDLE;
  // bus sees the word address, low bits return with the parcel
  assign haddr  = {req_q.adr[`IF_XLEN-1:2], 2'b00};
  assign hsize  = ifetch_pkg::WORD;
  assign hburst = ifetch_pkg::SINGLE;
  // read only
  assign hwrite = 1'b0;

  // hprot bits
  // 3 cacheable, 2 bufferable, 1 privileged, 0 data access
  assign hprot  = {req_q.cacheable, 1'b0, |req_q.prv, ~req_q.instruction};

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  // error rides along with the data
  assign biu_rsp.ack = data_done;
  assign biu_rsp.err = hresp;
  assign biu_rsp.adr = req_q.adr;
  assign biu_rsp.dat = hrdata;

  // slave must be ready when a new address goes out
  a_nonseq_ready : assert property (@(posedge clk) disable iff (!rstn || !`IF_SVA_ON)
    (htrans == ifetch_pkg::NONSEQ) |-> hready);

endmodule

//--- hw/ifetch_noicache.sv
`timescale 1ns/1ns
`include "ifetch_defines.svh"

module ifetch_noicache (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic [`IF_XLEN-1:0]  nxt_pc,
  input  logic [1:0]           prv,
  input  logic                 flush,
  input  logic                 parcel_ready,
  input  logic                 stb_ack,
  input  ifetch_pkg::biu_rsp_t biu_rsp,
  output logic                 stall_nxt_pc,
  output ifetch_pkg::parcel_t  parcel,
  output logic                 parcel_valid,
  output logic                 stb,
  output ifetch_pkg::biu_req_t biu_req
);

  // requests accepted since the last flush, saturating
  logic [1:0]             stb_cnt;
  logic                   flush_dly;
  // shift queue, entry 0 is the head
  logic [`IF_QDEPTH-1:0]  q_valid;
  logic [`IF_XLEN-1:0]    q_adr [`IF_QDEPTH];
  logic [`IF_PARCEL-1:0]  q_dat [`IF_QDEPTH];
  logic [`IF_QDEPTH-1:0]  q_err;
  logic                   wr;
  logic                   rd;

  //////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////

  // msb set is the io region, never cached
  assign biu_req.adr         = nxt_pc;
  assign biu_req.prv         = prv;
  assign biu_req.cacheable   = ~nxt_pc[`IF_IO_BIT];
  assign biu_req.instruction = 1'b1;

  // no new address once entry 1 holds a parcel
  // entry 2 is kept for the read already in flight
  // a flush empties the queue so it may always issue
  assign stb          = flush | ~q_valid[1];
  assign stall_nxt_pc = ~stb | ~stb_ack;

  //////////////////////////////////////////////////
  // decode side
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      flush_dly <= 1'b0;
    end else begin
      flush_dly <= flush;
    end
  end

  // masked in the flush cycle and the one after
  assign parcel_valid = q_valid[0] & ~(flush | flush_dly);

  assign parcel.pc         = q_adr[0];
  assign parcel.insn       = q_dat[0];
  // only full words fetched, low bits flag a bad target
  assign parcel.misaligned = |q_adr[0][1:0];
  assign parcel.bus_err    = q_err[0];

  assign wr = biu_rsp.ack;
  assign rd = parcel_valid & parcel_ready;

  //////////////////////////////////////////////////
  // queue control
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      stb_cnt <= 2'b00;
    end else if (flush) begin
      // a request taken in the flush cycle is already new
      stb_cnt <= {1'b0, stb_ack};
    end else if (stb_ack && stb_cnt != 2'b11) begin
      stb_cnt <= stb_cnt + 2'b01;
    end
  end

  // stale responses land while the counter is still zero
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      q_valid <= '0;
    end else if (flush || stb_cnt == 2'b00) begin
      q_valid <= '0;
    end else begin
      case ({wr, rd})
        2'b10: begin
          // fill the first free entry
          if (q_valid[1] && q_valid[0]) begin
            q_valid[2] <= 1'b1;
          end else if (q_valid[0]) begin
            q_valid <= 3'b011;
          end else begin
            q_valid <= 3'b001;
          end
        end
        2'b01: begin
          // pop head
          q_valid <= {1'b0, q_valid[2:1]};
        end
        // idle, or read and fill together
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // queue payload
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    case ({wr, rd})
      2'b10: begin
        if (q_valid[1] && q_valid[0]) begin
          q_adr[2] <= biu_rsp.adr;
          q_dat[2] <= biu_rsp.dat;
          q_err[2] <= biu_rsp.err;
        end else if (q_valid[0]) begin
          q_adr[1] <= biu_rsp.adr;
          q_dat[1] <= biu_rsp.dat;
          q_err[1] <= biu_rsp.err;
        end else begin
          q_adr[0] <= biu_rsp.adr;
          q_dat[0] <= biu_rsp.dat;
          q_err[0] <= biu_rsp.err;
        end
      end
      2'b01: begin
        q_adr[0] <= q_adr[1];
        q_dat[0] <= q_dat[1];
        q_err[0] <= q_err[1];
        q_adr[1] <= q_adr[2];
        q_dat[1] <= q_dat[2];
        q_err[1] <= q_err[2];
      end
      2'b11: begin
        if (q_valid[2]) begin
          // full, shift and refill the tail
          q_adr[2] <= biu_rsp.adr;
          q_dat[2] <= biu_rsp.dat;
          q_err[2] <= biu_rsp.err;
          q_adr[1] <= q_adr[2];
          q_dat[1] <= q_dat[2];
          q_err[1] <= q_err[2];
          q_adr[0] <= q_adr[1];
          q_dat[0] <= q_dat[1];
          q_err[0] <= q_err[1];
        end else if (q_valid[1]) begin
          q_adr[1] <= biu_rsp.adr;
          q_dat[1] <= biu_rsp.dat;
          q_err[1] <= biu_rsp.err;
          q_adr[0] <= q_adr[1];
          q_dat[0] <= q_dat[1];
          q_err[0] <= q_err[1];
        end else begin
          // single entry replaced in place
          q_adr[0] <= biu_rsp.adr;
          q_dat[0] <= biu_rsp.dat;
          q_err[0] <= biu_rsp.err;
        end
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // stall on entry 1 must leave room for the read in flight
  a_no_overflow : assert property (@(posedge clk) disable iff (!rstn || !`IF_SVA_ON)
    (&q_valid && !rd && !flush) |-> !biu_rsp.ack);

  // head is held for decode until taken
  a_parcel_hold : assert property (@(posedge clk) disable iff (!rstn || !`IF_SVA_ON)
    (parcel_valid && !parcel_ready) |=> $stable(parcel));

endmodule

//--- hw/ifetch_pc_seq.sv
`timescale 1ns/1ns
`include "ifetch_defines.svh"

module ifetch_pc_seq (
  input  logic                  clk,
  input  logic                  rstn,
  input  ifetch_pkg::redirect_t redirect,
  input  logic                  stall_nxt_pc,
  input  logic                  stb_fire,
  output logic [`IF_XLEN-1:0]   nxt_pc,
  output logic [1:0]            prv
);

  //////////////////////////////////////////////////
  // sequencer state
  //////////////////////////////////////////////////

  // address of the next fetch not yet taken by the bus
  logic [`IF_XLEN-1:0] pc;
  // privilege the fetches are issued under
  logic [1:0]          prv_q;

  // redirect bypasses the register
  // so the fetch slot of the redirect cycle is used
  assign nxt_pc = redirect.valid ? redirect.pc : pc;
  assign prv    = redirect.valid ? redirect.prv : prv_q;

  //////////////////////////////////////////////////
  // pc update
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pc    <= `IF_RESET_PC;
      // machine level out of reset
      prv_q <= 2'b11;
    end else begin
      if (redirect.valid) begin
        prv_q <= redirect.prv;
      end

      // request went out, step past it
      // covers a request taken in the redirect cycle too
      if (stb_fire && !stall_nxt_pc) begin
        pc <= nxt_pc + `IF_XLEN'd4;
      end else if (redirect.valid) begin
        // not taken yet, hold the new target
        pc <= redirect.pc;
      end
    end
  end

endmodule

//--- hw/ifetch_pkg.sv
`include "ifetch_defines.svh"

package ifetch_pkg;

  //////////////////////////////////////////////////
  // ahb-lite encodings
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  typedef enum logic [2:0] {
    BYTE  = 3'b000,
    HWORD = 3'b001,
    WORD  = 3'b010,
    DWORD = 3'b011
  } hsize_e;

  // fetch only ever uses single
  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001
  } hburst_e;

  // bus interface unit fsm
  typedef enum logic [1:0] {
    BIU_IDLE = 2'b00,
    BIU_ADDR = 2'b01,
    BIU_DATA = 2'b10
  } biu_state_e;

  //////////////////////////////////////////////////
  // bundles between the blocks
  //////////////////////////////////////////////////

  // branch, trap or flush from the core
  typedef struct packed {
    logic                valid;
    logic [`IF_XLEN-1:0] pc;
    logic [1:0]          prv;
  } redirect_t;

  // one fetched instruction towards decode
  typedef struct packed {
    logic [`IF_XLEN-1:0]   pc;
    logic [`IF_PARCEL-1:0] insn;
    logic                  misaligned;
    logic                  bus_err;
  } parcel_t;

  // fetch request into the bus interface unit
  typedef struct packed {
    logic [`IF_XLEN-1:0] adr;
    logic [1:0]          prv;
    logic                cacheable;
    logic                instruction;
  } biu_req_t;

  // completed read, ack is a single-cycle pulse
  typedef struct packed {
    logic                ack;
    logic                err;
    logic [`IF_XLEN-1:0] adr;
    logic [`IF_XLEN-1:0] dat;
  } biu_rsp_t;

endpackage

//--- hw/ifetch_defines.svh
`ifndef IFETCH_DEFINES_SVH
`define IFETCH_DEFINES_SVH

//////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////

// address and bus data width
`define IF_XLEN 32
// one instruction parcel, no compressed support
`define IF_PARCEL 32
// entries in the fetch parcel queue
`define IF_QDEPTH 3

//////////////////////////////////////////////////
// memory map and checks
//////////////////////////////////////////////////

// first fetch address out of reset
`define IF_RESET_PC 32'h0000_0100
// msb set means uncached io region
`define IF_IO_BIT 31
// global enable for the protocol assertions
`define IF_SVA_ON 1'b1

`endif
